//--- design/mac_stat_pkg.sv
`default_nettype none

package mac_stat_pkg;

    localparam int STAT_DATA_W = 32;  // Host read word
    localparam int SHORT_W     = 16;
    localparam int FCS_CNT_W   = 3;   // Bad FCS count per cycle from the MAC
    localparam int STAT_ADDR_W = 4;

    // Short counters stop here
    localparam logic [SHORT_W-1:0] SHORT_MAX = '1;

    // Host read address map, unlisted addresses read zero
    localparam logic [STAT_ADDR_W-1:0] ADDR_LATCH      = 4'd0;
    localparam logic [STAT_ADDR_W-1:0] ADDR_RX_PKT     = 4'd1;
    localparam logic [STAT_ADDR_W-1:0] ADDR_RX_LOST    = 4'd2;
    localparam logic [STAT_ADDR_W-1:0] ADDR_RX_BEATS   = 4'd3;
    localparam logic [STAT_ADDR_W-1:0] ADDR_RX_BAD_FCS = 4'd4;
    localparam logic [STAT_ADDR_W-1:0] ADDR_RX_MAX_LEN = 4'd5;
    localparam logic [STAT_ADDR_W-1:0] ADDR_TX_PKT     = 4'd6;
    localparam logic [STAT_ADDR_W-1:0] ADDR_TX_BEATS   = 4'd7;
    localparam logic [STAT_ADDR_W-1:0] ADDR_TX_MAX_LEN = 4'd8;
    localparam logic [STAT_ADDR_W-1:0] ADDR_TX_OVF     = 4'd9;
    localparam logic [STAT_ADDR_W-1:0] ADDR_TX_UNF     = 4'd10;
    localparam logic [STAT_ADDR_W-1:0] ADDR_IDLE       = 4'd11;  // Bit 0 rx, bit 1 tx

endpackage

`default_nettype wire

//--- design/mon_stat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mon_stat_if #(
    parameter int CNT_W = 32
);
    logic [CNT_W-1:0]                 pkt_cnt;
    logic [CNT_W-1:0]                 beat_cnt;
    logic [CNT_W-1:0]                 aux_cnt;    // Lost beats on rx
    logic [mac_stat_pkg::SHORT_W-1:0] err_a_cnt;  // Bad FCS on rx, overflow on tx
    logic [mac_stat_pkg::SHORT_W-1:0] err_b_cnt;  // Underflow on tx
    logic [mac_stat_pkg::SHORT_W-1:0] max_len;
    logic                             idle;

    modport monitor (output pkt_cnt, output beat_cnt, output aux_cnt, output err_a_cnt,
                     output err_b_cnt, output max_len, output idle);
    modport snapshot (input pkt_cnt, input beat_cnt, input aux_cnt, input err_a_cnt,
                      input err_b_cnt, input max_len, input idle);
endinterface

`default_nettype wire

//--- design/snap_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface snap_rd_if;
    logic                                 capture;
    logic [mac_stat_pkg::STAT_ADDR_W-1:0] addr;
    logic [mac_stat_pkg::STAT_DATA_W-1:0] data;
    logic [mac_stat_pkg::SHORT_W-1:0]     seq;

    // Read port side
    modport reader (output capture, output addr, input data, input seq);

    modport bank (input capture, input addr, output data, output seq);
endinterface

`default_nettype wire

//--- design/cmac_recv_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module cmac_recv_monitor #(
    parameter int CNT_W = 32
) (
    input  logic                                gt_txusrclk2,
    input  logic                                rst_n,
    input  logic                                valid,
    input  logic                                ready,
    input  logic                                last,
    input  logic                                user,
    input  logic [mac_stat_pkg::FCS_CNT_W-1:0]  bad_fcs,
    mon_stat_if.monitor                         stat
);
    localparam int SW = mac_stat_pkg::SHORT_W;

    logic          beat;
    logic          lost;
    logic [SW:0]   fcs_sum;
    logic [SW-1:0] cur_len;
    logic [SW-1:0] pkt_len;

    assign beat    = valid && ready;
    assign lost    = valid && !ready;  // MAC cannot stall, the beat is gone
    assign fcs_sum = {1'b0, stat.err_a_cnt} + (SW + 1)'(bad_fcs);
    // Length including this beat, held at the limit
    assign pkt_len = (cur_len == mac_stat_pkg::SHORT_MAX) ? cur_len : cur_len + 1'b1;

    assign stat.err_b_cnt = '0;

    // Length and idle follow accepted beats only
    always_ff @(posedge gt_txusrclk2 or negedge rst_n) begin
        if (!rst_n) begin
            stat.pkt_cnt   <= '0;
            stat.beat_cnt  <= '0;
            stat.aux_cnt   <= '0;
            stat.err_a_cnt <= '0;
            stat.max_len   <= '0;
            stat.idle      <= 1'b1;
            cur_len        <= '0;
        end else begin
            if (beat) begin
                stat.beat_cnt <= stat.beat_cnt + 1'b1;
                stat.idle     <= last;
                if (last) begin
                    stat.pkt_cnt <= stat.pkt_cnt + 1'b1;
                    cur_len      <= '0;
                    if (pkt_len > stat.max_len)
                        stat.max_len <= pkt_len;
                end else begin
                    cur_len <= pkt_len;
                end
            end
            if (lost)
                stat.aux_cnt <= stat.aux_cnt + 1'b1;
            stat.err_a_cnt <= fcs_sum[SW] ? mac_stat_pkg::SHORT_MAX : fcs_sum[SW-1:0];
        end
    end

    // Refused beats are the only source of lost count
    assert property (@(posedge gt_txusrclk2) disable iff (!rst_n)
        ready |=> $stable(stat.aux_cnt));

    assert property (@(posedge gt_txusrclk2) disable iff (!rst_n)
        (valid && user) |-> last);  // Error flag rides on the last beat

endmodule

`default_nettype wire

//--- design/cmac_send_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module cmac_send_monitor #(
    parameter int CNT_W = 32
) (
    input  logic        gt_txusrclk2,
    input  logic        rst_n,
    input  logic        valid,
    input  logic        ready,
    input  logic        last,
    input  logic        tx_ovf,
    input  logic        tx_unf,
    mon_stat_if.monitor stat
);
    logic                             beat;
    logic [mac_stat_pkg::SHORT_W-1:0] cur_len;
    logic [mac_stat_pkg::SHORT_W-1:0] pkt_len;

    assign beat    = valid && ready;
    assign pkt_len = (cur_len == mac_stat_pkg::SHORT_MAX) ? cur_len : cur_len + 1'b1;

    assign stat.aux_cnt = '0;  // Nothing is lost on transmit

    always_ff @(posedge gt_txusrclk2 or negedge rst_n) begin
        if (!rst_n) begin
            stat.pkt_cnt   <= '0;
            stat.beat_cnt  <= '0;
            stat.err_a_cnt <= '0;
            stat.err_b_cnt <= '0;
            stat.max_len   <= '0;
            stat.idle      <= 1'b1;
            cur_len        <= '0;
        end else begin
            if (beat) begin
                stat.beat_cnt <= stat.beat_cnt + 1'b1;
                stat.idle     <= last;
                if (last) begin
                    stat.pkt_cnt <= stat.pkt_cnt + 1'b1;
                    cur_len      <= '0;
                    if (pkt_len > stat.max_len)
                        stat.max_len <= pkt_len;
                end else begin
                    cur_len <= pkt_len;
                end
            end
            if (tx_ovf && stat.err_a_cnt != mac_stat_pkg::SHORT_MAX)
                stat.err_a_cnt <= stat.err_a_cnt + 1'b1;
            if (tx_unf && stat.err_b_cnt != mac_stat_pkg::SHORT_MAX)
                stat.err_b_cnt <= stat.err_b_cnt + 1'b1;
        end
    end

    // Offered beat stays until taken
    assert property (@(posedge gt_txusrclk2) disable iff (!rst_n)
        (valid && !ready) |=> valid);

endmodule

`default_nettype wire

//--- design/stat_snapshot.sv
`timescale 1ns/1ps
`default_nettype none

module stat_snapshot #(
    parameter int CNT_W = 32
) (
    input  logic         gt_txusrclk2,
    input  logic         rst_n,
    mon_stat_if.snapshot rx_stat,
    mon_stat_if.snapshot tx_stat,
    snap_rd_if.bank      rd
);
    localparam int DW = mac_stat_pkg::STAT_DATA_W;

    logic [CNT_W-1:0]                 rx_pkt;
    logic [CNT_W-1:0]                 rx_lost;
    logic [CNT_W-1:0]                 rx_beats;
    logic [CNT_W-1:0]                 tx_pkt;
    logic [CNT_W-1:0]                 tx_beats;
    logic [mac_stat_pkg::SHORT_W-1:0] rx_bad_fcs;
    logic [mac_stat_pkg::SHORT_W-1:0] rx_max;
    logic [mac_stat_pkg::SHORT_W-1:0] tx_max;
    logic [mac_stat_pkg::SHORT_W-1:0] tx_ovf;
    logic [mac_stat_pkg::SHORT_W-1:0] tx_unf;
    logic [1:0]                       idle;  // {tx, rx}

    always_ff @(posedge gt_txusrclk2 or negedge rst_n) begin
        if (!rst_n) begin
            rx_pkt     <= '0;
            rx_lost    <= '0;
            rx_beats   <= '0;
            rx_bad_fcs <= '0;
            rx_max     <= '0;
            tx_pkt     <= '0;
            tx_beats   <= '0;
            tx_max     <= '0;
            tx_ovf     <= '0;
            tx_unf     <= '0;
            idle       <= 2'b11;
            rd.seq     <= '0;
        end else if (rd.capture) begin
            rx_pkt     <= rx_stat.pkt_cnt;
            rx_lost    <= rx_stat.aux_cnt;
            rx_beats   <= rx_stat.beat_cnt;
            rx_bad_fcs <= rx_stat.err_a_cnt;
            rx_max     <= rx_stat.max_len;
            tx_pkt     <= tx_stat.pkt_cnt;
            tx_beats   <= tx_stat.beat_cnt;
            tx_max     <= tx_stat.max_len;
            tx_ovf     <= tx_stat.err_a_cnt;
            tx_unf     <= tx_stat.err_b_cnt;
            idle       <= {tx_stat.idle, rx_stat.idle};
            rd.seq     <= rd.seq + 1'b1;
        end
    end

    // Latch address is answered by the read port from seq
    always_comb begin
        case (rd.addr)
            mac_stat_pkg::ADDR_RX_PKT:     rd.data = DW'(rx_pkt);
            mac_stat_pkg::ADDR_RX_LOST:    rd.data = DW'(rx_lost);
            mac_stat_pkg::ADDR_RX_BEATS:   rd.data = DW'(rx_beats);
            mac_stat_pkg::ADDR_RX_BAD_FCS: rd.data = DW'(rx_bad_fcs);
            mac_stat_pkg::ADDR_RX_MAX_LEN: rd.data = DW'(rx_max);
            mac_stat_pkg::ADDR_TX_PKT:     rd.data = DW'(tx_pkt);
            mac_stat_pkg::ADDR_TX_BEATS:   rd.data = DW'(tx_beats);
            mac_stat_pkg::ADDR_TX_MAX_LEN: rd.data = DW'(tx_max);
            mac_stat_pkg::ADDR_TX_OVF:     rd.data = DW'(tx_ovf);
            mac_stat_pkg::ADDR_TX_UNF:     rd.data = DW'(tx_unf);
            mac_stat_pkg::ADDR_IDLE:       rd.data = DW'(idle);
            default:                       rd.data = '0;
        endcase
    end

    // One capture per host latch read
    assert property (@(posedge gt_txusrclk2) disable iff (!rst_n)
        rd.capture |=> !rd.capture);

endmodule

`default_nettype wire

//--- design/stat_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module stat_read_port (
    input  logic                                   gt_txusrclk2,
    input  logic                                   rst_n,
    input  logic                                   rd_req,
    input  logic [mac_stat_pkg::STAT_ADDR_W-1:0]   rd_addr,
    output logic                                   rd_ack,
    output logic [mac_stat_pkg::STAT_DATA_W-1:0]   rd_data,
    snap_rd_if.reader                              rd
);
    localparam int DW = mac_stat_pkg::STAT_DATA_W;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ARM  = 2'd1;  // Capture cycle on a latch read
    localparam logic [1:0] S_WAIT = 2'd2;
    localparam logic [1:0] S_ACK  = 2'd3;

    logic [1:0]                           state;
    logic [mac_stat_pkg::STAT_ADDR_W-1:0] addr_q;
    logic                                 is_latch;

    always_ff @(posedge gt_txusrclk2 or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (rd_req) state <= S_ARM;
                S_ARM:   state <= S_WAIT;
                S_WAIT:  state <= S_ACK;
                default: if (!rd_req) state <= S_IDLE;  // Hold ack until req drops
            endcase
        end
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (state == S_IDLE && rd_req)
            addr_q <= rd_addr;
    end

    assign is_latch   = addr_q == mac_stat_pkg::ADDR_LATCH;
    assign rd.addr    = addr_q;
    assign rd.capture = (state == S_ARM) && is_latch;
    assign rd_ack     = state == S_ACK;
    assign rd_data    = !rd_ack ? '0 : (is_latch ? DW'(rd.seq) : rd.data);

    assert property (@(posedge gt_txusrclk2) disable iff (!rst_n)
        (rd_ack && rd_req) |=> rd_ack);

endmodule

`default_nettype wire

//--- design/cmac_stat_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmac_stat_top #(
    parameter int CNT_W = 32
) (
    input  logic                                   gt_txusrclk2,
    input  logic                                   rst_n,
    input  logic                                   rx_valid,
    input  logic                                   rx_ready,
    input  logic                                   rx_last,
    input  logic                                   rx_user,
    input  logic [mac_stat_pkg::FCS_CNT_W-1:0]     rx_bad_fcs,
    input  logic                                   tx_valid,
    input  logic                                   tx_ready,
    input  logic                                   tx_last,
    input  logic                                   tx_ovf,
    input  logic                                   tx_unf,
    input  logic                                   rd_req,
    input  logic [mac_stat_pkg::STAT_ADDR_W-1:0]   rd_addr,
    output logic                                   rd_ack,
    output logic [mac_stat_pkg::STAT_DATA_W-1:0]   rd_data
);
    mon_stat_if #(.CNT_W(CNT_W)) rx_stat ();
    mon_stat_if #(.CNT_W(CNT_W)) tx_stat ();
    snap_rd_if                   snap_rd ();

    cmac_recv_monitor #(.CNT_W(CNT_W)) recv_mon_i (
        .gt_txusrclk2 (gt_txusrclk2),
        .rst_n        (rst_n),
        .valid        (rx_valid),
        .ready        (rx_ready),
        .last         (rx_last),
        .user         (rx_user),
        .bad_fcs      (rx_bad_fcs),
        .stat         (rx_stat)
    );

    cmac_send_monitor #(.CNT_W(CNT_W)) send_mon_i (
        .gt_txusrclk2 (gt_txusrclk2),
        .rst_n        (rst_n),
        .valid        (tx_valid),
        .ready        (tx_ready),
        .last         (tx_last),
        .tx_ovf       (tx_ovf),
        .tx_unf       (tx_unf),
        .stat         (tx_stat)
    );

    stat_snapshot #(.CNT_W(CNT_W)) snapshot_i (
        .gt_txusrclk2 (gt_txusrclk2),
        .rst_n        (rst_n),
        .rx_stat      (rx_stat),
        .tx_stat      (tx_stat),
        .rd           (snap_rd)
    );

    stat_read_port read_port_i (
        .gt_txusrclk2 (gt_txusrclk2),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data),
        .rd           (snap_rd)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release 1 ns after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

`default_nettype wire

//--- tests/tb_cmac_stat.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmac_stat;
    localparam int CNT_W   = 32;
    localparam int AW      = mac_stat_pkg::STAT_ADDR_W;
    localparam int TIMEOUT = 50;  // Cycles allowed per handshake wait

    logic                                 clk;
    logic                                 rst_n;
    logic                                 rx_valid;
    logic                                 rx_ready;
    logic                                 rx_last;
    logic                                 rx_user;
    logic [mac_stat_pkg::FCS_CNT_W-1:0]   rx_bad_fcs;
    logic                                 tx_valid;
    logic                                 tx_ready;
    logic                                 tx_last;
    logic                                 tx_ovf;
    logic                                 tx_unf;
    logic                                 rd_req;
    logic [AW-1:0]                        rd_addr;
    logic                                 rd_ack;
    logic [mac_stat_pkg::STAT_DATA_W-1:0] rd_data;

    logic [31:0] model  [0:11];  // Live expected words by read address, seq at 0
    logic [31:0] frozen [0:11];  // As of the last latch
    int          rx_len;
    int          tx_len;
    int          err_cnt;
    int          tests_passed;
    int          tests_failed;
    string       word_name [0:11] = '{"seq", "rx_pkt", "rx_lost", "rx_beats", "rx_bad_fcs",
        "rx_max_len", "tx_pkt", "tx_beats", "tx_max_len", "tx_ovf", "tx_unf", "idle"};

    tb_clk_gen #(.PERIOD(8.0), .RST_CYCLES(5)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cmac_stat_top #(.CNT_W(CNT_W)) dut_i (
        .gt_txusrclk2 (clk),
        .rst_n        (rst_n),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_last      (rx_last),
        .rx_user      (rx_user),
        .rx_bad_fcs   (rx_bad_fcs),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_last      (tx_last),
        .tx_ovf       (tx_ovf),
        .tx_unf       (tx_unf),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data)
    );

    // Ack two cycles after the first sampled request, and never otherwise
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rd_req, 3) && !$past(rd_req, 4) && !$past(rd_ack, 3)) |-> $rose(rd_ack))
        else begin
            $display("At %0t rd_ack did not rise two cycles after rd_req", $time);
            err_cnt++;
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_ack) |-> ($past(rd_req, 3) && !$past(rd_req, 4)))
        else begin
            $display("At %0t rd_ack rose without a request two cycles earlier", $time);
            err_cnt++;
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_ack && rd_req) |=> rd_ack)
        else begin
            $display("At %0t rd_ack fell while rd_req was still high", $time);
            err_cnt++;
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_ack && !rd_req) |=> !rd_ack)
        else begin
            $display("At %0t rd_ack stayed high one cycle after rd_req dropped", $time);
            err_cnt++;
        end
    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_ack && $past(rd_ack)) |-> $stable(rd_data))
        else begin
            $display("At %0t rd_data changed while rd_ack was high", $time);
            err_cnt++;
        end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (rd_ack !== level && n < TIMEOUT) begin
            step();
            n++;
        end
        if (rd_ack !== level)
            abort_run($sformatf("Timeout at %0t, rd_ack never went to %0d", $time, level));
    endtask

    // hold keeps the request up for that many cycles after the ack
    task automatic host_read(input logic [AW-1:0] addr, input int hold,
                             output logic [31:0] data);
        rd_req  = 1'b1;
        rd_addr = addr;
        step();
        wait_ack(1'b1);
        data = rd_data;
        repeat (hold) step();
        rd_req = 1'b0;
        step();
        wait_ack(1'b0);
    endtask

    task automatic check_word(input logic [AW-1:0] addr, input logic [31:0] got);
        assert (got === frozen[addr]) else begin
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, word_name[addr], got,
                     frozen[addr]);
            err_cnt++;
        end
    endtask

    task automatic latch();
        logic [31:0] d;
        model[0] = model[0] + 1;
        frozen   = model;
        host_read(mac_stat_pkg::ADDR_LATCH, 0, d);
        check_word(mac_stat_pkg::ADDR_LATCH, d);
    endtask

    task automatic check_all();
        logic [31:0] d;
        for (int a = 1; a < 12; a++) begin
            host_read(AW'(a), 0, d);
            check_word(AW'(a), d);
        end
    endtask

    // Leaving close low stops short of the last beat
    task automatic send_rx(input int len, input bit rand_ready, input bit rand_fcs,
                           input bit close);
        int sum;
        for (int i = 0; i < len; i++) begin
            rx_valid   = 1'b1;
            rx_last    = close && i == len - 1;
            rx_user    = rx_last && $urandom_range(1) == 1;
            rx_ready   = !rand_ready || $urandom_range(3) != 0;
            rx_bad_fcs = rand_fcs ? (mac_stat_pkg::FCS_CNT_W)'($urandom_range(7)) : '0;
            sum        = model[4] + rx_bad_fcs;
            model[4]   = sum > 32'hffff ? 32'hffff : sum;
            if (!rx_ready) begin
                model[2] = model[2] + 1;  // Beat dropped by the MAC
            end else begin
                model[3]     = model[3] + 1;
                rx_len       = rx_len + 1;
                model[11][0] = rx_last;
                if (rx_last) begin
                    model[1] = model[1] + 1;
                    if (rx_len > model[5])
                        model[5] = rx_len;
                    rx_len = 0;
                end
            end
            step();
        end
        rx_valid   = 1'b0;
        rx_last    = 1'b0;
        rx_user    = 1'b0;
        rx_bad_fcs = '0;
    endtask

    task automatic send_tx(input int len, input bit pulses, input bit close);
        int tries;
        for (int i = 0; i < len; i++) begin
            tx_valid = 1'b1;
            tx_last  = close && i == len - 1;
            tries    = 0;
            do begin
                tx_ready = tries == 7 || $urandom_range(2) != 0;
                tx_ovf   = pulses && $urandom_range(4) == 0;
                tx_unf   = pulses && $urandom_range(4) == 0;
                if (tx_ovf)
                    model[9] = model[9] + 1;
                if (tx_unf)
                    model[10] = model[10] + 1;
                tries++;
                step();
            end while (!tx_ready);
            model[7]     = model[7] + 1;
            tx_len       = tx_len + 1;
            model[11][1] = tx_last;
            if (tx_last) begin
                model[6] = model[6] + 1;
                if (tx_len > model[8])
                    model[8] = tx_len;
                tx_len = 0;
            end
        end
        tx_valid = 1'b0;
        tx_last  = 1'b0;
        tx_ovf   = 1'b0;
        tx_unf   = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int          mark;
        logic [31:0] d;
        void'($urandom(32'h0b4d_6eef));
        rx_valid     = 1'b0;
        rx_ready     = 1'b0;
        rx_last      = 1'b0;
        rx_user      = 1'b0;
        rx_bad_fcs   = '0;
        tx_valid     = 1'b0;
        tx_ready     = 1'b0;
        tx_last      = 1'b0;
        tx_ovf       = 1'b0;
        tx_unf       = 1'b0;
        rd_req       = 1'b0;
        rd_addr      = '0;
        rx_len       = 0;
        tx_len       = 0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int a = 0; a < 12; a++)
            model[a] = '0;
        model[11] = 32'd3;  // Both streams idle
        frozen    = model;

        mark = 0;
        while (!rst_n && mark < 20) begin
            step();
            mark++;
        end
        if (!rst_n)
            abort_run("Reset was never released");
        step();

        mark = err_cnt;
        latch();
        check_all();
        finish_test("reset values", mark);

        mark = err_cnt;
        repeat (8) send_rx($urandom_range(20, 1), 1'b0, 1'b0, 1'b1);
        latch();
        check_all();
        finish_test("rx traffic with ready high", mark);

        mark = err_cnt;
        repeat (8) send_rx($urandom_range(20, 1), 1'b1, 1'b1, 1'b1);
        latch();
        check_all();
        finish_test("rx traffic with lost beats and bad FCS", mark);

        mark = err_cnt;
        repeat (8) send_tx($urandom_range(20, 1), 1'b1, 1'b1);
        latch();
        check_all();
        finish_test("tx traffic with back-pressure and pulses", mark);

        mark = err_cnt;
        send_rx(6, 1'b1, 1'b0, 1'b1);
        send_tx(5, 1'b0, 1'b1);
        check_all();  // Still the old snapshot
        latch();
        check_all();
        send_rx(3, 1'b0, 1'b0, 1'b0);
        send_tx(2, 1'b0, 1'b0);
        latch();
        check_all();
        send_rx(2, 1'b0, 1'b0, 1'b1);
        send_tx(2, 1'b0, 1'b1);
        latch();
        check_all();
        finish_test("snapshot freeze and idle", mark);

        mark = err_cnt;
        repeat (6) begin
            rd_addr = AW'($urandom_range(11, 1));
            host_read(rd_addr, $urandom_range(3, 1), d);
            check_word(rd_addr, d);
        end
        finish_test("host handshake", mark);

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
design/mac_stat_pkg.sv
design/mon_stat_if.sv
design/snap_rd_if.sv
design/cmac_recv_monitor.sv
design/cmac_send_monitor.sv
design/stat_snapshot.sv
design/stat_read_port.sv
design/cmac_stat_top.sv
tests/tb_clk_gen.sv
tests/tb_cmac_stat.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cmac_stat \
    -f sources.f \
    -o tb_cmac_stat_sim

./obj_dir/tb_cmac_stat_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
